/* verilog/rob_cfg_pkg.sv */
// sizing constants and index types for the reorder buffer, register file and predictor
package rob_cfg_pkg;

  // reorder buffer geometry
  localparam int rob_depth = 128;
  localparam int rob_id_w  = $clog2(rob_depth);

  typedef logic [rob_id_w-1:0] rob_id_t;
  // top bit is the wrap polarity, tells full from empty
  typedef logic [rob_id_w:0]   rob_ptr_t;

  // datapath
  localparam int xlen = 32;

  typedef logic [xlen-1:0] data_t;
  // word address, byte offset dropped
  typedef logic [xlen-1:2] pc_t;

  // architectural registers
  localparam int nregs = 32;

  typedef logic [$clog2(nregs)-1:0] reg_idx_t;
  // msb set means no destination
  typedef logic [$clog2(nregs):0]   rd_field_t;

  // branch counter table
  localparam int bptag_w    = 16;
  localparam int bp_entries = 2 ** bptag_w;

  typedef logic [bptag_w-1:0] bptag_t;

endpackage

/* verilog/rob_op_pkg.sv */
// retire-op encoding, exception cause codes and the trap vector reset value
package rob_op_pkg;

  // retire op as carried with each instruction
  localparam int retop_w = 7;

  typedef logic [retop_w-1:0] retop_t;

  // conditional branch, trained at retire
  localparam int retop_branch = 6;
  // branch taken when result bit 0 is clear
  localparam int retop_invert = 5;
  // unconditional jump, always redirects
  localparam int retop_jump   = 4;
  // store, released to memory at retire
  localparam int retop_store  = 3;
  // bits 2..0 belong to the execution units and are ignored here

  // exception causes
  localparam int ecause_w = 5;

  typedef logic [ecause_w-1:0] ecause_t;
  // decode only reports the low causes, widened on insert
  typedef logic [1:0]          decode_ecause_t;

  localparam ecause_t cause_misaligned = 5'd0;
  localparam ecause_t cause_fault      = 5'd1;
  localparam ecause_t cause_illegal    = 5'd2;

  // trap vector after reset, word address of byte 0x100
  localparam rob_cfg_pkg::pc_t mtvec_reset = 30'h0000_0040;

endpackage

/* verilog/rob.sv */
// reorder buffer: in-order insert from decode, out-of-order writeback, one retire per cycle
`timescale 1ns/1ps

module rob (
  input  logic                       clk,
  input  logic                       rst_n,
  // decode
  input  logic                       decode_valid,
  input  logic                       decode_error,
  input  rob_op_pkg::decode_ecause_t decode_ecause,
  input  rob_op_pkg::retop_t         decode_retop,
  input  rob_cfg_pkg::pc_t           decode_addr,
  input  rob_cfg_pkg::rd_field_t     decode_rd,
  input  rob_cfg_pkg::bptag_t        decode_bptag,
  input  logic                       decode_bptaken,
  input  logic                       decode_forward,
  input  rob_cfg_pkg::pc_t           decode_target,
  output logic                       rob_full,
  output rob_cfg_pkg::rob_id_t       rob_robid,
  // rename
  input  logic                       rename_inhibit,
  output rob_cfg_pkg::rob_id_t       rename_head,
  // writeback
  input  logic                       wb_valid,
  input  logic                       wb_error,
  input  rob_op_pkg::ecause_t        wb_ecause,
  input  rob_cfg_pkg::rob_id_t       wb_robid,
  input  rob_cfg_pkg::data_t         wb_result,
  // redirect
  output logic                       flush,
  output rob_cfg_pkg::pc_t           flush_pc,
  // commit and predictor training
  output logic                       ret_valid,
  output logic                       ret_commit,
  output rob_cfg_pkg::reg_idx_t      ret_rd,
  output rob_cfg_pkg::data_t         ret_result,
  output logic                       ret_branch,
  output rob_cfg_pkg::bptag_t        ret_bptag,
  output logic                       ret_taken,
  output logic                       ret_store,
  // trap
  input  rob_cfg_pkg::pc_t           tvec,
  output logic                       csr_valid,
  output rob_cfg_pkg::rob_id_t       csr_head,
  output rob_cfg_pkg::pc_t           csr_epc,
  output rob_op_pkg::ecause_t        csr_ecause
);
  import rob_cfg_pkg::*;
  import rob_op_pkg::*;

  // entry storage
  logic [rob_depth-1:0] ent_executed;
  logic [rob_depth-1:0] ent_error;
  logic [rob_depth-1:0] ent_bptaken;
  logic [rob_depth-1:0] ent_forward;
  retop_t               ent_retop  [rob_depth];
  pc_t                  ent_addr   [rob_depth];
  rd_field_t            ent_rd     [rob_depth];
  ecause_t              ent_ecause [rob_depth];
  data_t                ent_result [rob_depth];
  pc_t                  ent_target [rob_depth];
  bptag_t               ent_bptag  [rob_depth];

  rob_ptr_t head_ptr;
  rob_ptr_t tail_ptr;
  rob_ptr_t head_next;
  rob_ptr_t rd_ptr;
  rob_id_t  rd_idx;
  logic     buf_empty;
  logic     buf_full;
  logic     rd_empty;
  logic     decode_beat;
  logic     wb_beat;
  logic     inhibit_q;

  // registered head entry
  logic      hd_valid;
  logic      hd_error;
  retop_t    hd_retop;
  pc_t       hd_addr;
  rd_field_t hd_rd;
  ecause_t   hd_ecause;
  data_t     hd_result;
  pc_t       hd_target;
  bptag_t    hd_bptag;
  logic      hd_bptaken;
  logic      hd_forward;

  logic br_outcome;
  logic hd_exc;
  logic hd_redirect;

  // while a retire is in progress the next read is head+1
  assign head_next = head_ptr + 1'b1;
  assign rd_ptr    = hd_valid ? head_next : head_ptr;
  assign rd_idx    = rd_ptr[rob_id_w-1:0];

  assign buf_empty = (head_ptr == tail_ptr);
  assign buf_full  = (head_ptr[rob_id_w-1:0] == tail_ptr[rob_id_w-1:0]) &&
                     (head_ptr[rob_id_w] != tail_ptr[rob_id_w]);
  assign rd_empty  = hd_valid ? (head_next == tail_ptr) : buf_empty;

  assign decode_beat = decode_valid && !buf_full;
  // writebacks right after an inhibit cycle are dropped
  assign wb_beat     = wb_valid && !inhibit_q;

  assign rob_full    = buf_full;
  assign rob_robid   = tail_ptr[rob_id_w-1:0];
  assign rename_head = rd_idx;

  // retire decisions
  assign br_outcome  = hd_result[0] ^ hd_retop[retop_invert];
  assign hd_exc      = hd_valid && hd_error;
  assign hd_redirect = hd_valid && (hd_retop[retop_jump] ||
                       (hd_retop[retop_branch] && (br_outcome != hd_bptaken)));

  assign flush    = hd_exc || hd_redirect;
  assign flush_pc = hd_error   ? tvec :
                    hd_forward ? pc_t'(hd_result[xlen-1:2]) : hd_target;

  assign ret_valid  = hd_valid && !hd_error;
  assign ret_commit = ret_valid && !hd_rd[$bits(rd_field_t)-1];
  assign ret_rd     = hd_rd[$bits(reg_idx_t)-1:0];
  // forwarded jumps commit the link address
  assign ret_result = hd_forward ? {hd_target, 2'b00} : hd_result;

  assign ret_branch = hd_valid && hd_retop[retop_branch];
  assign ret_bptag  = hd_bptag;
  assign ret_taken  = br_outcome;
  assign ret_store  = ret_valid && hd_retop[retop_store];

  assign csr_valid  = hd_exc;
  assign csr_head   = head_ptr[rob_id_w-1:0];
  assign csr_epc    = hd_addr;
  assign csr_ecause = hd_ecause;

  // pointers and retire strobe, flush empties the buffer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      inhibit_q <= 1'b0;
      hd_valid  <= 1'b0;
    end else if (flush) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      inhibit_q <= 1'b0;
      hd_valid  <= 1'b0;
    end else begin
      if (hd_valid) begin
        head_ptr <= head_next;
      end
      if (decode_beat) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      inhibit_q <= rename_inhibit;
      hd_valid  <= ent_executed[rd_idx] && !rd_empty;
    end
  end

  // head read
  always_ff @(posedge clk) begin
    hd_error   <= ent_error[rd_idx];
    hd_retop   <= ent_retop[rd_idx];
    hd_addr    <= ent_addr[rd_idx];
    hd_rd      <= ent_rd[rd_idx];
    hd_ecause  <= ent_ecause[rd_idx];
    hd_result  <= ent_result[rd_idx];
    hd_target  <= ent_target[rd_idx];
    hd_bptag   <= ent_bptag[rd_idx];
    hd_bptaken <= ent_bptaken[rd_idx];
    hd_forward <= ent_forward[rd_idx];
  end

  // insert at tail, writeback by id
  always_ff @(posedge clk) begin
    if (decode_beat) begin
      // stores and decode errors need no writeback
      ent_executed[rob_robid] <= decode_error || decode_retop[retop_store];
      ent_error[rob_robid]    <= decode_error;
      ent_retop[rob_robid]    <= decode_retop;
      ent_addr[rob_robid]     <= decode_addr;
      ent_rd[rob_robid]       <= decode_rd;
      ent_ecause[rob_robid]   <= ecause_t'(decode_ecause);
      ent_target[rob_robid]   <= decode_target;
      ent_bptag[rob_robid]    <= decode_bptag;
      ent_bptaken[rob_robid]  <= decode_bptaken;
      ent_forward[rob_robid]  <= decode_forward;
    end
    if (wb_beat) begin
      ent_executed[wb_robid] <= 1'b1;
      ent_error[wb_robid]    <= wb_error;
      ent_ecause[wb_robid]   <= wb_ecause;
      ent_result[wb_robid]   <= wb_result;
    end
  end

endmodule

/* verilog/arch_regs.sv */
// architectural register file, written at commit and read through one operand port
`timescale 1ns/1ps

module arch_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  // commit from retirement
  input  logic                  commit,
  input  rob_cfg_pkg::reg_idx_t rd,
  input  rob_cfg_pkg::data_t    result,
  // operand read
  input  rob_cfg_pkg::reg_idx_t rs_addr,
  output rob_cfg_pkg::data_t    rs_data
);
  import rob_cfg_pkg::*;

  data_t regs [nregs];

  // x0 is never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (commit && (rd != '0)) begin
      regs[rd] <= result;
    end
  end

  // x0 reads as zero
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule

/* verilog/branch_counters.sv */
// table of 2-bit saturating branch counters, trained at branch retire, read by lookup
`timescale 1ns/1ps

module branch_counters (
  input  logic                clk,
  input  logic                rst_n,
  // training from retirement
  input  logic                train,
  input  rob_cfg_pkg::bptag_t train_tag,
  input  logic                train_taken,
  // prediction lookup
  input  rob_cfg_pkg::bptag_t lookup_tag,
  output logic                lookup_taken
);
  import rob_cfg_pkg::*;

  logic [1:0] ctr [bp_entries];
  logic [1:0] cur_ctr;
  logic [1:0] new_ctr;

  assign cur_ctr = ctr[train_tag];

  // move toward the outcome, stop at 0 and 3
  always_comb begin
    new_ctr = cur_ctr;
    if (train_taken && (cur_ctr != 2'b11)) begin
      new_ctr = cur_ctr + 2'b01;
    end else if (!train_taken && (cur_ctr != 2'b00)) begin
      new_ctr = cur_ctr - 2'b01;
    end
  end

  // all start weakly not taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < bp_entries; i++) begin
        ctr[i] <= 2'b01;
      end
    end else if (train) begin
      ctr[train_tag] <= new_ctr;
    end
  end

  // taken at 2 or 3
  assign lookup_taken = ctr[lookup_tag][1];

endmodule

/* verilog/trap_csr.sv */
// trap CSRs (mtvec, mepc, mcause) and the retired instruction counter
`timescale 1ns/1ps

module trap_csr (
  input  logic                clk,
  input  logic                rst_n,
  // from retirement
  input  logic                ret_valid,
  input  logic                trap,
  input  rob_cfg_pkg::pc_t    epc,
  input  rob_op_pkg::ecause_t ecause,
  // CSR state
  output rob_cfg_pkg::pc_t    tvec,
  output rob_cfg_pkg::pc_t    mepc,
  output rob_op_pkg::ecause_t mcause,
  output logic [63:0]         instret
);
  import rob_cfg_pkg::*;
  import rob_op_pkg::*;

  // traps always vector to the reset value
  assign tvec = mtvec_reset;

  // trap record
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (trap) begin
      mepc   <= epc;
      mcause <= ecause;
    end
  end

  // trapped instructions do not count as retired
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instret <= '0;
    end else if (ret_valid) begin
      instret <= instret + 64'd1;
    end
  end

endmodule

/* verilog/retire_top.sv */
// retirement top level, connects the reorder buffer to its commit, predictor and trap blocks
`timescale 1ns/1ps

module retire_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // decode
  input  logic                       decode_valid,
  input  logic                       decode_error,
  input  rob_op_pkg::decode_ecause_t decode_ecause,
  input  rob_op_pkg::retop_t         decode_retop,
  input  rob_cfg_pkg::pc_t           decode_addr,
  input  rob_cfg_pkg::rd_field_t     decode_rd,
  input  rob_cfg_pkg::bptag_t        decode_bptag,
  input  logic                       decode_bptaken,
  input  logic                       decode_forward,
  input  rob_cfg_pkg::pc_t           decode_target,
  output logic                       rob_full,
  output rob_cfg_pkg::rob_id_t       rob_robid,
  // rename
  input  logic                       rename_inhibit,
  output rob_cfg_pkg::rob_id_t       rename_head,
  // writeback
  input  logic                       wb_valid,
  input  logic                       wb_error,
  input  rob_op_pkg::ecause_t        wb_ecause,
  input  rob_cfg_pkg::rob_id_t       wb_robid,
  input  rob_cfg_pkg::data_t         wb_result,
  // redirect and store release
  output logic                       flush,
  output rob_cfg_pkg::pc_t           flush_pc,
  output logic                       ret_store,
  // operand and prediction reads
  input  rob_cfg_pkg::reg_idx_t      rs_addr,
  output rob_cfg_pkg::data_t         rs_data,
  input  rob_cfg_pkg::bptag_t        lookup_tag,
  output logic                       lookup_taken,
  // trap state
  output rob_cfg_pkg::pc_t           mepc,
  output rob_op_pkg::ecause_t        mcause,
  output logic [63:0]                instret
);
  import rob_cfg_pkg::*;
  import rob_op_pkg::*;

  pc_t      tvec;
  logic     ret_valid;
  logic     ret_commit;
  reg_idx_t ret_rd;
  data_t    ret_result;
  logic     ret_branch;
  bptag_t   ret_bptag;
  logic     ret_taken;
  logic     csr_valid;
  pc_t      csr_epc;
  ecause_t  csr_ecause;

  rob u_rob (
    .clk            (clk),
    .rst_n          (rst_n),
    .decode_valid   (decode_valid),
    .decode_error   (decode_error),
    .decode_ecause  (decode_ecause),
    .decode_retop   (decode_retop),
    .decode_addr    (decode_addr),
    .decode_rd      (decode_rd),
    .decode_bptag   (decode_bptag),
    .decode_bptaken (decode_bptaken),
    .decode_forward (decode_forward),
    .decode_target  (decode_target),
    .rob_full       (rob_full),
    .rob_robid      (rob_robid),
    .rename_inhibit (rename_inhibit),
    .rename_head    (rename_head),
    .wb_valid       (wb_valid),
    .wb_error       (wb_error),
    .wb_ecause      (wb_ecause),
    .wb_robid       (wb_robid),
    .wb_result      (wb_result),
    .flush          (flush),
    .flush_pc       (flush_pc),
    .ret_valid      (ret_valid),
    .ret_commit     (ret_commit),
    .ret_rd         (ret_rd),
    .ret_result     (ret_result),
    .ret_branch     (ret_branch),
    .ret_bptag      (ret_bptag),
    .ret_taken      (ret_taken),
    .ret_store      (ret_store),
    .tvec           (tvec),
    .csr_valid      (csr_valid),
    .csr_head       (),
    .csr_epc        (csr_epc),
    .csr_ecause     (csr_ecause)
  );

  arch_regs u_arch_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .commit  (ret_commit),
    .rd      (ret_rd),
    .result  (ret_result),
    .rs_addr (rs_addr),
    .rs_data (rs_data)
  );

  branch_counters u_branch_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .train        (ret_branch),
    .train_tag    (ret_bptag),
    .train_taken  (ret_taken),
    .lookup_tag   (lookup_tag),
    .lookup_taken (lookup_taken)
  );

  trap_csr u_trap_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .ret_valid (ret_valid),
    .trap      (csr_valid),
    .epc       (csr_epc),
    .ecause    (csr_ecause),
    .tvec      (tvec),
    .mepc      (mepc),
    .mcause    (mcause),
    .instret   (instret)
  );

endmodule

/* verification/retire_properties.sv */
// concurrent checks on the reorder buffer retire logic, attached to every rob by bind
`timescale 1ns/1ps

module retire_properties (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic ret_commit,
  input logic hd_valid,
  input logic rob_full,
  input logic buf_empty
);

  // a flush leaves nothing in flight
  flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (buf_empty && !hd_valid))
    else $error("buffer not empty after a flush");

  // the committing entry still sits in the buffer
  commit_has_entry: assert property (@(posedge clk) disable iff (!rst_n)
    ret_commit |-> !buf_empty)
    else $error("commit with an empty buffer");

  // first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |-> !flush)
    else $error("flush high right after reset");

  // with no retire under way a full buffer stays full
  full_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (rob_full && !hd_valid) |=> rob_full)
    else $error("buffer left the full state with no retire");

endmodule

bind rob retire_properties u_retire_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .flush      (flush),
  .ret_commit (ret_commit),
  .hd_valid   (hd_valid),
  .rob_full   (rob_full),
  .buf_empty  (buf_empty)
);

/* verification/tb_retire.sv */
// testbench for the retirement top level, checks every retire against a reference model
`timescale 1ns/1ps

module tb_retire;
  import rob_cfg_pkg::*;
  import rob_op_pkg::*;

  typedef struct packed {
    logic      err;
    ecause_t   cause;
    retop_t    op;
    pc_t       addr;
    rd_field_t rd;
    bptag_t    tag;
    logic      bptaken;
    logic      fwd;
    pc_t       target;
    data_t     result;
  } ent_t;

  typedef struct packed {
    logic  flush;
    pc_t   flush_pc;
    logic  commit;
    data_t value;
    logic  store;
    logic  branch;
    logic  taken;
    logic  trap;
  } exp_t;

  logic           clk;
  logic           rst_n;
  logic           decode_valid;
  logic           decode_error;
  decode_ecause_t decode_ecause;
  retop_t         decode_retop;
  pc_t            decode_addr;
  rd_field_t      decode_rd;
  bptag_t         decode_bptag;
  logic           decode_bptaken;
  logic           decode_forward;
  pc_t            decode_target;
  logic           rob_full;
  rob_id_t        rob_robid;
  logic           rename_inhibit;
  rob_id_t        rename_head;
  logic           wb_valid;
  logic           wb_error;
  ecause_t        wb_ecause;
  rob_id_t        wb_robid;
  data_t          wb_result;
  logic           flush;
  pc_t            flush_pc;
  logic           ret_store;
  reg_idx_t       rs_addr;
  data_t          rs_data;
  bptag_t         lookup_tag;
  logic           lookup_taken;
  pc_t            mepc;
  ecause_t        mcause;
  logic [63:0]    instret;

  // reference state
  ent_t        ents [rob_depth];
  int          order_q[$];
  data_t       regs_m [nregs];
  int          ctr_m [int];
  logic [63:0] instret_m;
  pc_t         mepc_m;
  ecause_t     mcause_m;
  rob_id_t     head_m;
  int          seed;

  retire_top dut0 (.*);

  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
      fail_run("data check failed");
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
      fail_run("pc check failed");
    end
  endtask

  task automatic check_cause(input string name, input ecause_t got, input ecause_t want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
      fail_run("cause check failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
      fail_run("bit check failed");
    end
  endtask

  task automatic check_count(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, want);
      fail_run("count check failed");
    end
  endtask

  // expected retire behavior from the entry and its writeback state
  function automatic exp_t model_retire(input ent_t e);
    exp_t x;
    logic outcome;
    outcome  = e.result[0] ^ e.op[retop_invert];
    x.trap   = e.err;
    x.flush  = e.err || e.op[retop_jump] || (e.op[retop_branch] && (outcome != e.bptaken));
    if (e.err) begin
      x.flush_pc = mtvec_reset;
    end else if (e.fwd) begin
      x.flush_pc = e.result[31:2];
    end else begin
      x.flush_pc = e.target;
    end
    x.commit = !e.err && !e.rd[5];
    x.value  = e.fwd ? {e.target, 2'b00} : e.result;
    x.store  = !e.err && e.op[retop_store];
    x.branch = e.op[retop_branch];
    x.taken  = outcome;
    return x;
  endfunction

  always @(negedge clk) begin : compare_retire
    ent_t e;
    exp_t x;
    int   id;
    int   key;
    if (rst_n && (dut0.ret_valid || flush)) begin
      if (order_q.size() == 0) begin
        fail_run("a retire happened with no entry in flight");
      end else begin
        id = order_q.pop_front();
        e  = ents[id];
        x  = model_retire(e);
        check_bit("ret_valid", dut0.ret_valid, !e.err);
        check_bit("flush", flush, x.flush);
        if (x.flush) begin
          check_pc("flush_pc", flush_pc, x.flush_pc);
        end
        check_bit("ret_commit", dut0.ret_commit, x.commit);
        if (x.commit) begin
          check_data("ret_result", dut0.ret_result, x.value);
          if (e.rd[4:0] != '0) begin
            regs_m[e.rd[4:0]] = x.value;
          end
        end
        check_bit("ret_store", ret_store, x.store);
        check_bit("ret_branch", dut0.ret_branch, x.branch);
        if (x.branch) begin
          check_bit("ret_taken", dut0.ret_taken, x.taken);
          key = int'(e.tag);
          if (!ctr_m.exists(key)) begin
            ctr_m[key] = 1;
          end
          if (x.taken && ctr_m[key] < 3) begin
            ctr_m[key] = ctr_m[key] + 1;
          end else if (!x.taken && ctr_m[key] > 0) begin
            ctr_m[key] = ctr_m[key] - 1;
          end
        end
        check_bit("csr_valid", dut0.csr_valid, x.trap);
        if (x.trap) begin
          mepc_m   = e.addr;
          mcause_m = e.cause;
        end else begin
          instret_m = instret_m + 64'd1;
        end
        // everything younger is discarded
        if (x.flush) begin
          order_q.delete();
          head_m = '0;
        end else begin
          head_m = head_m + 1'b1;
        end
      end
    end
  end

  function automatic ent_t new_entry(input retop_t op, input rd_field_t rd);
    ent_t e;
    e.err     = 1'b0;
    e.cause   = '0;
    e.op      = op;
    e.addr    = pc_t'($random(seed));
    e.rd      = rd;
    e.tag     = bptag_t'($random(seed));
    e.bptaken = 1'b0;
    e.fwd     = 1'b0;
    e.target  = pc_t'($random(seed));
    e.result  = '0;
    return e;
  endfunction

  // called on a falling edge, returns on the next one
  task automatic insert_entry(input ent_t e, output rob_id_t id);
    int waited;
    waited = 0;
    while (rob_full) begin
      @(negedge clk);
      waited++;
      if (waited > 400) begin
        fail_run("timed out waiting for the buffer to accept an insert");
      end
    end
    id = rob_robid;
    ents[id] = e;
    order_q.push_back(int'(id));
    decode_valid   = 1'b1;
    decode_error   = e.err;
    decode_ecause  = e.cause[1:0];
    decode_retop   = e.op;
    decode_addr    = e.addr;
    decode_rd      = e.rd;
    decode_bptag   = e.tag;
    decode_bptaken = e.bptaken;
    decode_forward = e.fwd;
    decode_target  = e.target;
    @(negedge clk);
    decode_valid = 1'b0;
  endtask

  // applied is low for a writeback the buffer must drop
  task automatic write_back(input rob_id_t id, input logic err, input ecause_t cause,
                            input data_t value, input logic applied);
    wb_valid  = 1'b1;
    wb_robid  = id;
    wb_error  = err;
    wb_ecause = cause;
    wb_result = value;
    if (applied) begin
      ents[id].err    = err;
      ents[id].cause  = cause;
      ents[id].result = value;
    end
    @(negedge clk);
    wb_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (order_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > 1000) begin
        fail_run("timed out waiting for the buffer to retire everything");
      end
    end
    repeat (3) @(negedge clk);
    // empty buffer, head and tail both sit at the next free slot
    check_data("rename_head", data_t'(rename_head), data_t'(head_m));
    check_data("rob_robid", data_t'(rob_robid), data_t'(head_m));
  endtask

  task automatic check_regs();
    for (int r = 0; r < nregs; r++) begin
      rs_addr = reg_idx_t'(r);
      @(posedge clk);
      check_data("rs_data", rs_data, regs_m[r]);
      @(negedge clk);
    end
  endtask

  task automatic check_lookup(input bptag_t tag);
    int c;
    c = ctr_m.exists(int'(tag)) ? ctr_m[int'(tag)] : 1;
    lookup_tag = tag;
    @(posedge clk);
    check_bit("lookup_taken", lookup_taken, c >= 2);
    @(negedge clk);
  endtask

  task automatic alu_wave(input int n, input logic fill);
    rob_id_t ids[$];
    rob_id_t id;
    rob_id_t tmp;
    int      j;
    for (int i = 0; i < n; i++) begin
      insert_entry(new_entry('0, rd_field_t'($random(seed))), id);
      ids.push_back(id);
    end
    if (fill) begin
      check_bit("rob_full", rob_full, 1'b1);
      // oldest first so the held insert gets space
      write_back(ids[0], 1'b0, '0, data_t'($random(seed)), 1'b1);
      void'(ids.pop_front());
      insert_entry(new_entry('0, rd_field_t'($random(seed))), id);
      ids.push_back(id);
    end else begin
      for (int i = ids.size() - 1; i > 0; i--) begin
        j = $unsigned($random(seed)) % (i + 1);
        tmp = ids[i];
        ids[i] = ids[j];
        ids[j] = tmp;
      end
    end
    foreach (ids[k]) begin
      write_back(ids[k], 1'b0, '0, data_t'($random(seed)), 1'b1);
    end
    wait_drain();
    check_regs();
    check_count("instret", instret, instret_m);
  endtask

  initial begin
    ent_t    e;
    rob_id_t a;
    rob_id_t b;
    rob_id_t c;
    seed = 32'h6200;
    clk = 1'b0;
    rst_n = 1'b0;
    decode_valid = 1'b0;
    decode_error = 1'b0;
    decode_ecause = '0;
    decode_retop = '0;
    decode_addr = '0;
    decode_rd = '0;
    decode_bptag = '0;
    decode_bptaken = 1'b0;
    decode_forward = 1'b0;
    decode_target = '0;
    rename_inhibit = 1'b0;
    wb_valid = 1'b0;
    wb_error = 1'b0;
    wb_ecause = '0;
    wb_robid = '0;
    wb_result = '0;
    rs_addr = '0;
    lookup_tag = '0;
    instret_m = '0;
    mepc_m = '0;
    mcause_m = '0;
    head_m = '0;
    foreach (regs_m[r]) begin
      regs_m[r] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // random writeback order
    alu_wave(24, 1'b0);

    // stores and a decode error, the trailing alu is flushed
    insert_entry(new_entry('0, 6'd4), a);
    insert_entry(new_entry(retop_t'(1 << retop_store), 6'h20), b);
    e = new_entry('0, 6'd5);
    e.err = 1'b1;
    e.cause = cause_illegal;
    insert_entry(e, c);
    insert_entry(new_entry('0, 6'd6), c);
    write_back(a, 1'b0, '0, data_t'($random(seed)), 1'b1);
    write_back(c, 1'b0, '0, data_t'($random(seed)), 1'b1);
    wait_drain();
    check_pc("mepc", mepc, mepc_m);
    check_cause("mcause", mcause, mcause_m);
    check_data("rob_robid", data_t'(rob_robid), '0);

    // writeback error
    insert_entry(new_entry('0, 6'd8), a);
    insert_entry(new_entry('0, 6'd9), b);
    write_back(a, 1'b1, cause_fault, data_t'($random(seed)), 1'b1);
    write_back(b, 1'b0, '0, data_t'($random(seed)), 1'b1);
    wait_drain();
    check_pc("mepc", mepc, mepc_m);
    check_cause("mcause", mcause, mcause_m);

    // writeback dropped after an inhibit cycle
    insert_entry(new_entry('0, 6'd11), a);
    rename_inhibit = 1'b1;
    @(negedge clk);
    rename_inhibit = 1'b0;
    write_back(a, 1'b0, '0, 32'hdead_beef, 1'b0);
    repeat (4) @(negedge clk);
    check_bit("entry still in flight", order_q.size() == 1, 1'b1);
    write_back(a, 1'b0, '0, data_t'($random(seed)), 1'b1);
    wait_drain();

    // predicted branches train tag 1234 up to strongly taken
    for (int i = 0; i < 3; i++) begin
      e = new_entry(retop_t'(1 << retop_branch), 6'h20);
      e.tag = 16'h1234;
      e.bptaken = 1'b1;
      insert_entry(e, a);
      write_back(a, 1'b0, '0, data_t'($random(seed)) | 32'd1, 1'b1);
    end
    wait_drain();
    // mispredict flushes the alu behind it
    e = new_entry(retop_t'(1 << retop_branch), 6'h20);
    e.tag = 16'h1234;
    insert_entry(e, a);
    insert_entry(new_entry('0, 6'd7), b);
    write_back(b, 1'b0, '0, data_t'($random(seed)), 1'b1);
    write_back(a, 1'b0, '0, 32'd1, 1'b1);
    wait_drain();
    check_data("rob_robid", data_t'(rob_robid), '0);
    // forwarded jump
    e = new_entry(retop_t'(1 << retop_jump), 6'd9);
    e.fwd = 1'b1;
    insert_entry(e, a);
    insert_entry(new_entry('0, 6'd10), b);
    write_back(b, 1'b0, '0, data_t'($random(seed)), 1'b1);
    write_back(a, 1'b0, '0, data_t'($random(seed)), 1'b1);
    wait_drain();
    // inverted branches train tag 00f0 down
    for (int i = 0; i < 2; i++) begin
      e = new_entry(retop_t'((1 << retop_branch) | (1 << retop_invert)), 6'h20);
      e.tag = 16'h00f0;
      insert_entry(e, a);
      write_back(a, 1'b0, '0, 32'd1, 1'b1);
    end
    wait_drain();
    check_lookup(16'h1234);
    check_lookup(16'h00f0);
    check_lookup(16'hbeef);
    check_regs();

    // full buffer holds off the next insert
    alu_wave(rob_depth, 1'b1);

    $display("Regression passed");
    $finish;
  end

endmodule

/* sources.f */
verilog/rob_cfg_pkg.sv
verilog/rob_op_pkg.sv
verilog/rob.sv
verilog/arch_regs.sv
verilog/branch_counters.sv
verilog/trap_csr.sv
verilog/retire_top.sv
verification/retire_properties.sv
verification/tb_retire.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_retire: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_retire -o Vtb_retire

run: obj_dir/Vtb_retire
	./obj_dir/Vtb_retire > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
